// ==== spectrum_pkg.sv ====
package spectrum_pkg;

	// flat RAM address
	// banks sit in region 000, ROM pages above region marker 001
	localparam int ram_addr_w = 21;

	// CPU clock select
	typedef enum logic [2:0] {
		speed_3m5 = 3'd0,
		speed_7m  = 3'd1,
		speed_14m = 3'd2,
		speed_28m = 3'd3,
		speed_56m = 3'd4
	} cpu_speed_e;

	// divider mask per speed, indexed by cpu_speed_e
	// each step clears one more top bit and halves the period
	localparam logic [0:4][4:0] turbo_mask = {
		5'b11111,
		5'b01111,
		5'b00111,
		5'b00011,
		5'b00001
	};

	// memory map flavour
	typedef enum logic [1:0] {
		mem_128k  = 2'd0,
		mem_48k   = 2'd1,
		mem_plus3 = 2'd2
	} memory_mode_e;

	// what the CPU drives onto the bus
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  dout;
		// I/O write cycle, never set during M1
		logic        io_wr;
		logic        mem_wr;
		logic        m1;
	} cpu_bus_t;

	// mixed sound output
	typedef struct packed {
		logic [15:0] left;
		logic [15:0] right;
	} audio_t;

	// low-byte decodes for the DAC ports
	localparam logic [7:0] port_covox = 8'hfb;
	localparam logic [7:0] port_sd_a  = 8'h0f;
	localparam logic [7:0] port_sd_b  = 8'h1f;
	localparam logic [7:0] port_sd_c  = 8'h4f;
	localparam logic [7:0] port_sd_d  = 8'h5f;

	// fixed banks of the 128K map
	localparam logic [2:0] screen_bank = 3'd5;
	localparam logic [2:0] fixed_bank  = 3'd2;

endpackage

// ==== speed_control.sv ====
module speed_control (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  spectrum_pkg::cpu_speed_e speed,
	input  logic                     pause,
	output logic                     ce_cpu_p,
	output logic                     ce_cpu_n
);

	logic [5:0] counter;
	logic [5:0] masked;
	logic [4:0] turbo;
	logic [4:0] turbo_req;
	logic [4:0] half_point;
	logic       cpu_p;
	logic       cpu_n;
	logic       cpu_en;
	logic [1:0] timeout;

	// codes past the last speed fall back to 3.5 MHz
	always_comb begin
		if (speed > spectrum_pkg::speed_56m) begin
			turbo_req = spectrum_pkg::turbo_mask[spectrum_pkg::speed_3m5];
		end else begin
			turbo_req = spectrum_pkg::turbo_mask[speed];
		end
	end

	// counter bit 5 never survives the mask
	assign masked = counter & {1'b0, turbo};

	// top set bit of the mask marks half a period
	assign half_point = turbo ^ (turbo >> 1);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			counter <= '0;
			cpu_p <= 1'b0;
			cpu_n <= 1'b0;
		end else begin
			counter <= counter + 6'd1;
			cpu_p <= (masked == 6'd0);
			cpu_n <= (masked == {1'b0, half_point});
		end
	end

	// mask switch and pause only act on the falling phase
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			turbo <= spectrum_pkg::turbo_mask[spectrum_pkg::speed_3m5];
			cpu_en <= 1'b1;
			timeout <= 2'd0;
		end else if (cpu_n) begin
			if (timeout != 2'd0) begin
				timeout <= timeout + 2'd1;
			end
			if (turbo != turbo_req) begin
				// halt the CPU while the new rate settles
				cpu_en <= 1'b0;
				timeout <= 2'd1;
				turbo <= turbo_req;
			end else if (!cpu_en && (timeout == 2'd0)) begin
				cpu_en <= ~pause;
			end else if (cpu_en && pause) begin
				cpu_en <= 1'b0;
			end
		end
	end

	assign ce_cpu_p = cpu_en & cpu_p;
	assign ce_cpu_n = cpu_en & cpu_n;

	// the two phases must stay apart across every mask change
	phase_split: assert property (@(posedge clk_sys) disable iff (reset)
		!(ce_cpu_p && ce_cpu_n));

endmodule

// ==== memory_pager.sv ====
module memory_pager (
	input  logic                               clk_sys,
	input  logic                               reset,
	input  spectrum_pkg::memory_mode_e         mode,
	input  spectrum_pkg::cpu_bus_t             bus,
	output logic [spectrum_pkg::ram_addr_w-1:0] ram_addr,
	output logic                               ram_we
);

	spectrum_pkg::memory_mode_e memory_mode;

	logic [7:0] page_reg;
	logic [7:0] page_reg_plus3;
	logic [1:0] wr_sync;
	logic       io_write;
	logic       wr_rise;
	logic       zx48;
	logic       plus3;
	logic       page_disable;
	logic       page_write;
	logic       page_write_plus3;
	logic       page_special;
	logic [3:0] page_rom;
	logic [spectrum_pkg::ram_addr_w-15:0] bank_hi;

	assign io_write = bus.io_wr & ~bus.m1;

	// edge of the delayed strobe, so the write lands one clock later
	assign wr_rise = wr_sync[0] & ~wr_sync[1];

	assign zx48  = (memory_mode == spectrum_pkg::mem_48k);
	assign plus3 = (memory_mode == spectrum_pkg::mem_plus3);

	// 48K never pages, others lock through 7FFD bit 5
	assign page_disable = zx48 | page_reg[5];

	// +3 also needs A14 high for 7FFD
	assign page_write = ~bus.addr[15] & ~bus.addr[1] & (bus.addr[14] | ~plus3) &
		~page_disable;

	assign page_write_plus3 = ~bus.addr[15] & ~bus.addr[14] & ~bus.addr[13] &
		bus.addr[12] & ~bus.addr[1] & plus3 & ~page_disable;

	assign page_special = page_reg_plus3[0];

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			wr_sync <= 2'b00;
			page_reg <= 8'h00;
			page_reg_plus3 <= 8'h00;
			memory_mode <= mode;
		end else begin
			wr_sync <= {wr_sync[0], io_write};
			if (wr_rise) begin
				if (page_write) begin
					page_reg <= bus.dout;
				end else if (page_write_plus3) begin
					page_reg_plus3 <= bus.dout;
				end
			end
		end
	end

	// 48K gets page 15, 128K pages 6/7, +3 pages 8 to 11
	assign page_rom = plus3 ? {2'b10, page_reg_plus3[2], page_reg[4]} :
		{zx48, 2'b11, zx48 | page_reg[4]};

	always_comb begin
		bank_hi = '0;
		if (page_special) begin
			// all-RAM maps, bank set picked by 1FFD bits 2..1
			case (bus.addr[15:14])
				2'b00: bank_hi = {4'd0, |page_reg_plus3[2:1], 2'b00};
				2'b01: bank_hi = {4'd0, |page_reg_plus3[2:1], &page_reg_plus3[2:1], 1'b1};
				2'b10: bank_hi = {4'd0, |page_reg_plus3[2:1], 2'b10};
				default: bank_hi = {4'd0, ~page_reg_plus3[2] & page_reg_plus3[1], 2'b11};
			endcase
		end else begin
			case (bus.addr[15:14])
				2'b00: bank_hi = {3'b001, page_rom};
				2'b01: bank_hi = {4'd0, spectrum_pkg::screen_bank};
				2'b10: bank_hi = {4'd0, spectrum_pkg::fixed_bank};
				default: bank_hi = {4'd0, page_reg[2:0]};
			endcase
		end
	end

	assign ram_addr = {bank_hi, bus.addr[13:0]};

	// ROM window is read only outside the special map
	assign ram_we = bus.mem_wr & (page_special | bus.addr[15] | bus.addr[14]);

	// 1FFD only loads in +3 mode, so ROM-window writes imply that mode
	rom_write_guard: assert property (@(posedge clk_sys) disable iff (reset)
		(ram_we && (bus.addr[15:14] == 2'b00)) |->
			(page_special && (memory_mode == spectrum_pkg::mem_plus3)));

endmodule

// ==== sound_ports.sv ====
module sound_ports (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  spectrum_pkg::cpu_bus_t bus,
	input  logic                   ear_in,
	output logic [2:0]             border,
	output spectrum_pkg::audio_t   audio
);

	logic            io_write;
	logic            fe_sel;
	logic            covox_sel;
	logic [3:0]      sd_sel;
	logic            ear_out;
	logic            mic_out;
	// left pair 0/1, right pair 2/3
	logic [3:0][7:0] dac;

	// sum of two DAC bytes plus the beeper bits
	function automatic logic [15:0] mix(
		input logic [7:0] a,
		input logic [7:0] b,
		input logic [2:0] beep
	);
		mix = {3'd0, a, 5'd0} + {3'd0, b, 5'd0} + {2'd0, beep, 11'd0};
	endfunction

	assign io_write = bus.io_wr & ~bus.m1;

	assign fe_sel    = io_write & ~bus.addr[0];
	assign covox_sel = io_write & (bus.addr[7:0] == spectrum_pkg::port_covox);

	assign sd_sel[0] = io_write & (bus.addr[7:0] == spectrum_pkg::port_sd_a);
	assign sd_sel[1] = io_write & (bus.addr[7:0] == spectrum_pkg::port_sd_b);
	assign sd_sel[2] = io_write & (bus.addr[7:0] == spectrum_pkg::port_sd_c);
	assign sd_sel[3] = io_write & (bus.addr[7:0] == spectrum_pkg::port_sd_d);

	always_ff @(posedge clk_sys) begin
		if (fe_sel) begin
			border <= bus.dout[2:0];
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ear_out <= 1'b0;
			mic_out <= 1'b0;
			dac <= '0;
		end else begin
			if (fe_sel) begin
				ear_out <= bus.dout[4];
				mic_out <= bus.dout[3];
			end
			// covox fills every channel at once
			for (int i = 0; i < 4; i++) begin
				if (covox_sel | sd_sel[i]) begin
					dac[i] <= bus.dout;
				end
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		audio.left  <= mix(dac[0], dac[1], {ear_out, mic_out, ear_in});
		audio.right <= mix(dac[2], dac[3], {ear_out, mic_out, ear_in});
	end

endmodule

// ==== spectrum_core.sv ====
module spectrum_core (
	input  logic                                clk_sys,
	input  logic                                reset,
	input  spectrum_pkg::cpu_speed_e            speed,
	input  logic                                pause,
	input  spectrum_pkg::memory_mode_e          mode,
	input  spectrum_pkg::cpu_bus_t              bus,
	input  logic                                ear_in,
	output logic                                ce_cpu_p,
	output logic                                ce_cpu_n,
	output logic [spectrum_pkg::ram_addr_w-1:0] ram_addr,
	output logic                                ram_we,
	output logic [2:0]                          border,
	output spectrum_pkg::audio_t                audio
);

	// CPU clock enables
	speed_control u_speed_control (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.speed    (speed),
		.pause    (pause),
		.ce_cpu_p (ce_cpu_p),
		.ce_cpu_n (ce_cpu_n)
	);

	// 7FFD/1FFD paging and RAM address
	memory_pager u_memory_pager (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.mode     (mode),
		.bus      (bus),
		.ram_addr (ram_addr),
		.ram_we   (ram_we)
	);

	// FE port and DAC latches
	sound_ports u_sound_ports (
		.clk_sys (clk_sys),
		.reset   (reset),
		.bus     (bus),
		.ear_in  (ear_in),
		.border  (border),
		.audio   (audio)
	);

endmodule

// ==== tb_clock.sv ====
module tb_clock (
	input  logic restart,
	output logic clk_sys,
	output logic reset
);
	timeunit 1ns;
	timeprecision 1ps;

	localparam int reset_cycles = 8;

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	// power-on reset, then again on every restart request
	initial begin
		reset = 1'b1;
		repeat (reset_cycles) @(posedge clk_sys);
		#1;
		reset = 1'b0;
		forever begin
			@(posedge restart);
			reset = 1'b1;
			repeat (reset_cycles) @(posedge clk_sys);
			#1;
			reset = 1'b0;
		end
	end

endmodule

// ==== spectrum_tb.sv ====
module spectrum_tb;
	timeunit 1ns;
	timeprecision 1ps;

	// rough cycle budget of each test
	localparam int speed_test_cycles = 5 * 300;
	localparam int pause_test_cycles = 250;
	localparam int paging_128k_cycles = 150;
	localparam int paging_plus3_cycles = 150;
	localparam int paging_48k_cycles = 60;
	localparam int sound_test_cycles = 120;
	localparam int watchdog_cycles = 2 * (speed_test_cycles + pause_test_cycles +
		paging_128k_cycles + paging_plus3_cycles + paging_48k_cycles + sound_test_cycles);

	logic                                clk_sys;
	logic                                reset;
	logic                                restart;
	spectrum_pkg::cpu_speed_e            speed;
	logic                                pause;
	spectrum_pkg::memory_mode_e          mode;
	spectrum_pkg::cpu_bus_t              bus;
	logic                                ear_in;
	logic                                ce_cpu_p;
	logic                                ce_cpu_n;
	logic [spectrum_pkg::ram_addr_w-1:0] ram_addr;
	logic                                ram_we;
	logic [2:0]                          border;
	spectrum_pkg::audio_t                audio;

	int          error_count;
	int          check_count;
	logic [15:0] lfsr_state;

	// expected state of the sound latches
	logic [7:0]  dac_model [4];
	logic        ear_model;
	logic        mic_model;

	tb_clock u_clock (
		.restart (restart),
		.clk_sys (clk_sys),
		.reset   (reset)
	);

	spectrum_core DUT (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.speed    (speed),
		.pause    (pause),
		.mode     (mode),
		.bus      (bus),
		.ear_in   (ear_in),
		.ce_cpu_p (ce_cpu_p),
		.ce_cpu_n (ce_cpu_n),
		.ram_addr (ram_addr),
		.ram_we   (ram_we),
		.border   (border),
		.audio    (audio)
	);

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] state);
		logic feedback;
		feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
		lfsr_next = {state[14:0], feedback};
	endfunction

	task automatic draw_bits(input int count, output logic [15:0] value);
		value = '0;
		for (int i = 0; i < count; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			value = {value[14:0], lfsr_state[0]};
		end
	endtask

	// all driving and sampling happens just after the rising edge
	task automatic wait_cycle;
		@(posedge clk_sys);
		#1;
	endtask

	task automatic check_value(input string test_name, input logic [31:0] expected,
		input logic [31:0] actual);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("Error %s: expected %h, actual %h", test_name, expected, actual);
		end
	endtask

	task automatic report_failure(input string what);
		error_count++;
		$display("%s", what);
	endtask

	task automatic restart_dut(input spectrum_pkg::memory_mode_e new_mode);
		int waited;
		bus = '0;
		mode = new_mode;
		restart = 1'b1;
		wait_cycle;
		restart = 1'b0;
		waited = 0;
		while (reset && waited < 20) begin
			wait_cycle;
			waited++;
		end
		if (reset) begin
			report_failure("reset stayed high after a restart request");
		end
	endtask

	task automatic io_write_cycle(input logic [15:0] addr, input logic [7:0] data);
		bus.addr = addr;
		bus.dout = data;
		bus.mem_wr = 1'b0;
		bus.m1 = 1'b0;
		bus.io_wr = 1'b1;
		repeat (4) wait_cycle;
		bus.io_wr = 1'b0;
		wait_cycle;
	endtask

	task automatic probe_addr(input logic [15:0] addr, input logic write);
		bus.addr = addr;
		bus.mem_wr = write;
		wait_cycle;
	endtask

	task automatic wait_for_pulse(output bit found);
		int waited;
		found = 1'b0;
		waited = 0;
		while (!found && waited < 64) begin
			wait_cycle;
			waited++;
			if (ce_cpu_p) begin
				found = 1'b1;
			end
		end
	endtask

	// gap between two ce_cpu_p pulses, with one ce_cpu_n inside it
	task automatic measure_spacing(input string test_name, input int expected);
		bit found;
		int gap;
		int n_count;
		wait_for_pulse(found);
		if (!found) begin
			report_failure({test_name, ": no ce_cpu_p pulse within 64 cycles"});
		end else begin
			gap = 0;
			n_count = 0;
			found = 1'b0;
			while (!found && gap < 64) begin
				wait_cycle;
				gap++;
				if (ce_cpu_n) begin
					n_count++;
				end
				if (ce_cpu_p) begin
					found = 1'b1;
				end
			end
			check_value(test_name, expected, gap);
			check_value({test_name, " ce_cpu_n count"}, 1, n_count);
		end
	endtask

	// known +3 all-RAM configurations
	function automatic logic [2:0] special_bank(input int set, input int window);
		case (set)
			0: special_bank = 3'(window);
			1: special_bank = 3'(4 + window);
			2: special_bank = (window == 3) ? 3'd3 : 3'(4 + window);
			default: begin
				case (window)
					0: special_bank = 3'd4;
					1: special_bank = 3'd7;
					2: special_bank = 3'd6;
					default: special_bank = 3'd3;
				endcase
			end
		endcase
	endfunction

	function automatic logic [15:0] expected_mix(input logic [7:0] a, input logic [7:0] b,
		input logic [2:0] beep);
		expected_mix = 16'(a * 32 + b * 32 + beep * 2048);
	endfunction

	task automatic test_speed_spacing;
		for (int s = 0; s < 5; s++) begin
			speed = spectrum_pkg::cpu_speed_e'(s);
			repeat (200) wait_cycle;
			measure_spacing($sformatf("speed spacing %0d", s), 32 >> s);
		end
	endtask

	task automatic test_pause;
		int pulses;
		pause = 1'b1;
		repeat (100) wait_cycle;
		pulses = 0;
		repeat (64) begin
			wait_cycle;
			if (ce_cpu_p || ce_cpu_n) begin
				pulses++;
			end
		end
		check_value("pause pulses", 0, pulses);
		pause = 1'b0;
		measure_spacing("pause release spacing", 2);
	endtask

	task automatic test_paging_128k;
		logic [15:0] rnd;
		logic [7:0]  data;
		logic [13:0] offset;
		logic [2:0]  locked_bank;
		for (int i = 0; i < 6; i++) begin
			draw_bits(8, rnd);
			data = rnd[7:0] & 8'hdf;
			io_write_cycle(16'h7ffd, data);
			draw_bits(14, rnd);
			offset = rnd[13:0];
			probe_addr({2'b11, offset}, 1'b0);
			check_value("128k upper bank", {4'b0000, data[2:0], offset}, ram_addr);
			probe_addr({2'b00, offset}, 1'b0);
			check_value("128k rom page", {3'b001, (data[4] ? 4'd7 : 4'd6), offset}, ram_addr);
		end
		probe_addr({2'b01, offset}, 1'b0);
		check_value("128k screen bank", {4'b0000, 3'd5, offset}, ram_addr);
		probe_addr({2'b10, offset}, 1'b0);
		check_value("128k fixed bank", {4'b0000, 3'd2, offset}, ram_addr);
		// lock, then try to move the upper bank
		draw_bits(8, rnd);
		data = rnd[7:0] | 8'h20;
		locked_bank = data[2:0];
		io_write_cycle(16'h7ffd, data);
		io_write_cycle(16'h7ffd, {5'b00000, ~locked_bank});
		probe_addr(16'hc000, 1'b0);
		check_value("128k locked bank", {4'b0000, locked_bank, 14'd0}, ram_addr);
		restart_dut(spectrum_pkg::mem_128k);
		probe_addr(16'hc000, 1'b0);
		check_value("128k bank after reset", 21'd0, ram_addr);
		io_write_cycle(16'h7ffd, {5'b00000, ~locked_bank});
		probe_addr(16'hc000, 1'b0);
		check_value("128k unlocked bank", {4'b0000, ~locked_bank, 14'd0}, ram_addr);
	endtask

	task automatic test_paging_plus3;
		logic [15:0] rnd;
		logic [13:0] offset;
		logic [3:0]  rom_page;
		restart_dut(spectrum_pkg::mem_plus3);
		for (int combo = 0; combo < 4; combo++) begin
			io_write_cycle(16'h1ffd, {5'b00000, combo[1], 2'b00});
			io_write_cycle(16'h7ffd, {3'b000, combo[0], 4'b0000});
			draw_bits(14, rnd);
			offset = rnd[13:0];
			rom_page = 4'(8 + 2 * combo[1] + combo[0]);
			probe_addr({2'b00, offset}, 1'b0);
			check_value("plus3 rom page", {3'b001, rom_page, offset}, ram_addr);
		end
		for (int set = 0; set < 4; set++) begin
			io_write_cycle(16'h1ffd, {5'b00000, set[1:0], 1'b1});
			for (int window = 0; window < 4; window++) begin
				draw_bits(14, rnd);
				offset = rnd[13:0];
				probe_addr({window[1:0], offset}, 1'b1);
				check_value("plus3 special bank",
					{4'b0000, special_bank(set, window), offset}, ram_addr);
				check_value("plus3 special ram_we", 1, ram_we);
			end
		end
		io_write_cycle(16'h1ffd, 8'h00);
		probe_addr(16'h0000, 1'b1);
		check_value("plus3 rom ram_we", 0, ram_we);
		bus.mem_wr = 1'b0;
	endtask

	task automatic test_paging_48k;
		logic [15:0] rnd;
		logic [13:0] offset;
		restart_dut(spectrum_pkg::mem_48k);
		draw_bits(8, rnd);
		io_write_cycle(16'h7ffd, (rnd[7:0] & 8'hdf) | 8'h11);
		draw_bits(14, rnd);
		offset = rnd[13:0];
		probe_addr({2'b11, offset}, 1'b0);
		check_value("48k upper bank", {4'b0000, 3'd0, offset}, ram_addr);
		probe_addr({2'b00, offset}, 1'b1);
		check_value("48k rom page", {3'b001, 4'd15, offset}, ram_addr);
		check_value("48k rom ram_we", 0, ram_we);
		probe_addr({2'b01, offset}, 1'b1);
		check_value("48k screen ram_we", 1, ram_we);
		probe_addr({2'b11, offset}, 1'b1);
		check_value("48k upper ram_we", 1, ram_we);
		probe_addr({2'b10, offset}, 1'b0);
		check_value("48k idle ram_we", 0, ram_we);
	endtask

	// both channels, with ear_in low and then high
	task automatic check_audio(input string test_name);
		for (int v = 0; v < 2; v++) begin
			ear_in = v[0];
			repeat (2) wait_cycle;
			check_value({test_name, " left"},
				expected_mix(dac_model[0], dac_model[1], {ear_model, mic_model, ear_in}),
				audio.left);
			check_value({test_name, " right"},
				expected_mix(dac_model[2], dac_model[3], {ear_model, mic_model, ear_in}),
				audio.right);
		end
	endtask

	task automatic test_sound_ports;
		logic [15:0] rnd;
		logic [7:0]  data;
		logic [15:0] sd_port [4];
		sd_port[0] = 16'h000f;
		sd_port[1] = 16'h001f;
		sd_port[2] = 16'h004f;
		sd_port[3] = 16'h005f;
		// latches are clear since the last reset
		for (int i = 0; i < 4; i++) begin
			dac_model[i] = 8'h00;
		end
		ear_model = 1'b0;
		mic_model = 1'b0;
		for (int pass = 0; pass < 2; pass++) begin
			draw_bits(8, rnd);
			data = rnd[7:0];
			io_write_cycle(16'h00fe, data);
			ear_model = data[4];
			mic_model = data[3];
			check_value("sound border", data[2:0], border);
			check_audio("sound fe");
			draw_bits(8, rnd);
			data = rnd[7:0];
			io_write_cycle(16'h00fb, data);
			for (int i = 0; i < 4; i++) begin
				dac_model[i] = data;
			end
			check_audio("sound covox");
			for (int i = 0; i < 4; i++) begin
				draw_bits(8, rnd);
				data = rnd[7:0];
				io_write_cycle(sd_port[i], data);
				dac_model[i] = data;
				check_audio($sformatf("sound soundrive %0d", i));
			end
		end
	endtask

	initial begin
		int waited;
		speed = spectrum_pkg::speed_3m5;
		pause = 1'b0;
		mode = spectrum_pkg::mem_128k;
		bus = '0;
		ear_in = 1'b0;
		restart = 1'b0;
		lfsr_state = 16'd45;
		error_count = 0;
		check_count = 0;
		waited = 0;
		while (reset !== 1'b0 && waited < 20) begin
			wait_cycle;
			waited++;
		end
		if (reset !== 1'b0) begin
			report_failure("power-on reset never released");
		end
		test_speed_spacing;
		test_pause;
		test_paging_128k;
		test_paging_plus3;
		test_paging_48k;
		test_sound_ports;
		$display("summary: %0d checks, %0d errors", check_count, error_count);
		if (error_count == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

	initial begin
		repeat (watchdog_cycles) @(posedge clk_sys);
		$display("watchdog expired after %0d cycles, tests did not finish", watchdog_cycles);
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

// ==== spectrum.f ====
spectrum_pkg.sv
speed_control.sv
memory_pager.sv
sound_ports.sv
spectrum_core.sv
tb_clock.sv
spectrum_tb.sv

// ==== Bender.yml ====
package:
  name: spectrum

sources:
  - spectrum_pkg.sv
  - speed_control.sv
  - memory_pager.sv
  - sound_ports.sv
  - spectrum_core.sv
  - target: test
    files:
      - tb_clock.sv
      - spectrum_tb.sv
